//--- design/dsp_multiplier.sv
// ========================================
// Signed 16x16 multiplier driven through
// two operand registers. The product is
// registered and recomputed every cycle.
// ========================================

`timescale 1ns/1ps

module dsp_multiplier (
    input logic vdp_clk,
    input periph_pkg::periph_wr_t wr,
    output periph_pkg::product_t result
);
    import periph_pkg::*;

    half_t op_a;
    half_t op_b;

    // Operand registers and the registered product
    always_ff @(posedge vdp_clk) begin
        if (wr.dsp_a_we) begin
            op_a <= wr.data;
        end

        if (wr.dsp_b_we) begin
            op_b <= wr.data;
        end

        // Signed only
        result <= $signed(op_a) * $signed(op_b);
    end

    // Bus decode picks one operand per write
    assert property (@(posedge vdp_clk) wr.dsp_a_we |-> !wr.dsp_b_we)
        else $error("both operand strobes fired together");

endmodule

//--- design/flash_bitbang.sv
// ========================================
// CPU bit-bang control of the flash pins.
// While active the pins follow the control
// registers; otherwise they sit idle.
// ========================================

`timescale 1ns/1ps

`include "periph_defs.svh"

module flash_bitbang (
    input logic vdp_clk,
    input logic vdp_reset,
    input periph_pkg::periph_wr_t wr,
    output periph_pkg::flash_pins_t flash
);
    import periph_pkg::*;

    logic active_q;
    logic clk_q;
    logic csn_q;
    nibble_t in_q;
    nibble_t in_en_q;

    always_ff @(posedge vdp_clk) begin
        if (vdp_reset) begin
            active_q <= 1'b0;
            clk_q <= 1'b0;
            in_en_q <= '0;
        end else if (wr.flash_we) begin
            active_q <= wr.data[`FLASH_ACTIVE_BIT];
            clk_q <= wr.data[`FLASH_CLK_BIT];
            in_en_q <= wr.data[`FLASH_EN_LSB +: 4];
        end
    end

    // Pin data and chip select carry no reset
    always_ff @(posedge vdp_clk) begin
        if (wr.flash_we) begin
            in_q <= wr.data[`FLASH_IN_LSB +: 4];
            csn_q <= wr.data[`FLASH_CSN_BIT];
        end
    end

    always_comb begin
        if (active_q) begin
            flash.clk_ddr = {2{clk_q}};
            flash.csn = csn_q;
            flash.data_in = in_q;
            flash.data_in_en = in_en_q;
        end else begin
            // Idle: deselected, clock low, outputs off
            flash.clk_ddr = 2'b00;
            flash.csn = 1'b1;
            flash.data_in = '0;
            flash.data_in_en = '0;
        end
    end

    // A write with active clear leaves the pins idle
    assert property (@(posedge vdp_clk) disable iff (vdp_reset)
        (wr.flash_we && !wr.data[`FLASH_ACTIVE_BIT])
        |=> (flash.csn && flash.data_in_en == '0))
        else $error("flash pins driven while bit-bang inactive");

endmodule

//--- design/mmio_bus.sv
// ========================================
// Bus port of the peripheral block. Decodes
// a request, answers with a one-cycle ready
// pulse, strobes the target and holds the LEDs
// ========================================

`timescale 1ns/1ps

`include "periph_defs.svh"

module mmio_bus (
    input logic vdp_clk,
    input logic vdp_reset,
    input periph_pkg::mmio_req_t bus_req,
    output periph_pkg::mmio_rsp_t bus_rsp,
    output periph_pkg::periph_wr_t wr,
    input periph_pkg::product_t dsp_result,
    input logic [1:0] pad_bits,
    input periph_pkg::nibble_t flash_out,
    output logic led_r,
    output logic led_b
);
    import periph_pkg::*;

    periph_id_t sel_id;
    periph_id_t id_q;
    logic ready_q;
    logic write_q;
    logic opb_q;
    half_t data_q;
    data_t read_data;
    logic [1:0] status_q;
    logic accept;
    logic fire;

    // A valid seen during ready belongs to the ending transaction
    assign accept = bus_req.valid && !ready_q;
    assign fire = ready_q && write_q;

    always_comb begin
        case (bus_req.address[`SEL_MSB:`SEL_LSB])
            `SEL_STATUS: sel_id = PERIPH_STATUS;
            `SEL_DSP: sel_id = PERIPH_DSP;
            `SEL_PAD: sel_id = PERIPH_PAD;
            `SEL_FLASH: sel_id = PERIPH_FLASH;
            default: sel_id = PERIPH_NONE;
        endcase
    end

    always_ff @(posedge vdp_clk) begin
        if (vdp_reset) begin
            ready_q <= 1'b0;
            write_q <= 1'b0;
            id_q <= PERIPH_NONE;
        end else begin
            ready_q <= accept;
            if (accept) begin
                write_q <= |bus_req.wstrb;
                id_q <= sel_id;
            end
        end
    end

    // Payload and operand select captured with the request
    always_ff @(posedge vdp_clk) begin
        if (accept) begin
            opb_q <= bus_req.address[`DSP_OPB_BIT];
            data_q <= bus_req.write_data[15:0];
        end
    end

    always_comb begin
        wr.status_we = fire && (id_q == PERIPH_STATUS);
        wr.dsp_a_we = fire && (id_q == PERIPH_DSP) && !opb_q;
        wr.dsp_b_we = fire && (id_q == PERIPH_DSP) && opb_q;
        wr.pad_we = fire && (id_q == PERIPH_PAD);
        wr.flash_we = fire && (id_q == PERIPH_FLASH);
        wr.data = data_q;
    end

    // Status and unmapped reads return zero
    always_comb begin
        case (id_q)
            PERIPH_DSP: read_data = dsp_result;
            PERIPH_PAD: read_data = {{(`DATA_W-2){1'b0}}, pad_bits};
            PERIPH_FLASH: read_data = {{(`DATA_W-4){1'b0}}, flash_out};
            default: read_data = '0;
        endcase
        bus_rsp.ready = ready_q;
        bus_rsp.read_data = read_data;
    end

    always_ff @(posedge vdp_clk) begin
        if (vdp_reset) begin
            status_q <= `STATUS_RESET;
        end else if (wr.status_we) begin
            status_q <= wr.data[1:0];
        end
    end

    assign led_r = status_q[0];
    assign led_b = status_q[1];

    // Only one transaction in flight
    assert property (@(posedge vdp_clk) disable iff (vdp_reset) ready_q |=> !ready_q)
        else $error("ready held high for two cycles");

endmodule

//--- design/pad_reader.sv
// ========================================
// Gamepad reader. Mocks a serial pad with
// the board buttons: latch loads the shift
// register, a pad clock edge shifts it out.
// ========================================

`timescale 1ns/1ps

`include "periph_defs.svh"

module pad_reader (
    input logic vdp_clk,
    input periph_pkg::periph_wr_t wr,
    input periph_pkg::pad_buttons_t buttons,
    output logic [1:0] pad_bits
);
    logic [1:0] ctrl_q;
    logic pad_latch;
    logic pad_clk;
    logic pad_clk_q;
    logic [`PAD_SHIFT_W-1:0] latch_value;
    logic [`PAD_SHIFT_W-1:0] shift_q;
    logic user_q;

    assign pad_latch = ctrl_q[0];
    assign pad_clk = ctrl_q[1];

    always_ff @(posedge vdp_clk) begin
        if (wr.pad_we) begin
            ctrl_q <= wr.data[1:0];
        end
    end

    // B, left and right positions of a real pad
    always_comb begin
        latch_value = '0;
        latch_value[0] = buttons.btn_2;
        latch_value[6] = buttons.btn_3;
        latch_value[7] = buttons.btn_1;
    end

    always_ff @(posedge vdp_clk) begin
        if (pad_latch) begin
            shift_q <= latch_value;
        end

        // Shift wins when both happen
        if (pad_clk && !pad_clk_q) begin
            shift_q <= {1'b0, shift_q[`PAD_SHIFT_W-1:1]};
        end

        pad_clk_q <= pad_clk;
    end

    // User button through one register
    always_ff @(posedge vdp_clk) begin
        user_q <= buttons.btn_u;
    end

    assign pad_bits = {user_q, shift_q[0]};

endmodule

//--- design/periph_defs.svh
// ========================================
// Widths, address map and register bit
// positions of the peripheral block.
// Included by the package and the RTL.
// ========================================

`ifndef PERIPH_DEFS_SVH
`define PERIPH_DEFS_SVH

// Bus widths
`define ADDR_W 24
`define DATA_W 32

// Peripheral select field of the address
`define SEL_LSB 16
`define SEL_MSB 19
`define SEL_STATUS 4'd0
`define SEL_DSP 4'd1
`define SEL_PAD 4'd2
`define SEL_FLASH 4'd3

// Low selects operand A, high selects operand B
`define DSP_OPB_BIT 2

`define STATUS_RESET 2'b01
`define PAD_SHIFT_W 16

// Flash control word layout
`define FLASH_IN_LSB 0
`define FLASH_EN_LSB 4
`define FLASH_CLK_BIT 8
`define FLASH_CSN_BIT 9
`define FLASH_ACTIVE_BIT 15

`endif

//--- design/periph_pkg.sv
// ========================================
// Shared types of the peripheral block:
// bus words, request and response structs,
// write strobes and pin bundles.
// ========================================

`include "periph_defs.svh"

package periph_pkg;

    typedef logic [`ADDR_W-1:0] addr_t;
    typedef logic [`DATA_W-1:0] data_t;
    typedef logic [`DATA_W/8-1:0] wstrb_t;
    typedef logic [15:0] half_t;
    typedef logic signed [31:0] product_t;
    typedef logic [3:0] nibble_t;

    // Decoded bus target
    typedef enum logic [2:0] {
        PERIPH_NONE,
        PERIPH_STATUS,
        PERIPH_DSP,
        PERIPH_PAD,
        PERIPH_FLASH
    } periph_id_t;

    typedef struct packed {
        logic valid;
        addr_t address;
        data_t write_data;
        wstrb_t wstrb;
    } mmio_req_t;

    typedef struct packed {
        logic ready;
        data_t read_data;
    } mmio_rsp_t;

    // One-cycle strobes with the low half of the write data
    typedef struct packed {
        logic status_we;
        logic dsp_a_we;
        logic dsp_b_we;
        logic pad_we;
        logic flash_we;
        half_t data;
    } periph_wr_t;

    typedef struct packed {
        logic btn_u;
        logic btn_1;
        logic btn_2;
        logic btn_3;
    } pad_buttons_t;

    typedef struct packed {
        logic [1:0] clk_ddr;
        logic csn;
        nibble_t data_in;
        nibble_t data_in_en;
    } flash_pins_t;

endpackage

//--- design/periph_top.sv
// ========================================
// Top of the peripheral block. Connects the
// bus port to the multiplier, the gamepad
// reader and the flash bit-bang port.
// ========================================

`timescale 1ns/1ps

module periph_top (
    input logic vdp_clk,
    input logic vdp_reset,

    input periph_pkg::mmio_req_t bus_req,
    output periph_pkg::mmio_rsp_t bus_rsp,

    input periph_pkg::pad_buttons_t buttons,

    input periph_pkg::nibble_t flash_out,
    output periph_pkg::flash_pins_t flash,

    output logic led_r,
    output logic led_b
);
    import periph_pkg::*;

    periph_wr_t wr;
    product_t dsp_result;
    logic [1:0] pad_bits;

    mmio_bus u_mmio_bus (
        .vdp_clk(vdp_clk),
        .vdp_reset(vdp_reset),

        .bus_req(bus_req),
        .bus_rsp(bus_rsp),

        .wr(wr),

        .dsp_result(dsp_result),
        .pad_bits(pad_bits),
        // Registered in the pad cell outside this block
        .flash_out(flash_out),

        .led_r(led_r),
        .led_b(led_b)
    );

    dsp_multiplier u_dsp_multiplier (
        .vdp_clk(vdp_clk),
        .wr(wr),
        .result(dsp_result)
    );

    pad_reader u_pad_reader (
        .vdp_clk(vdp_clk),
        .wr(wr),
        .buttons(buttons),
        .pad_bits(pad_bits)
    );

    flash_bitbang u_flash_bitbang (
        .vdp_clk(vdp_clk),
        .vdp_reset(vdp_reset),
        .wr(wr),
        .flash(flash)
    );

endmodule

//--- tb.f
+incdir+design
design/periph_pkg.sv
design/mmio_bus.sv
design/dsp_multiplier.sv
design/pad_reader.sv
design/flash_bitbang.sv
design/periph_top.sv
tests/tb_periph_top.sv

//--- tests/tb_periph_top.sv
// ========================================
// Testbench of the peripheral block. Runs
// random bus traffic against a reference
// model and prints one line per test.
// ========================================

`timescale 1ns/1ps

`include "periph_defs.svh"

module tb_periph_top;
    import periph_pkg::*;

    // About 900 transactions of 2 cycles each, with margin
    localparam int MAX_CYCLES = 5000;

    logic vdp_clk = 1'b0;
    logic vdp_reset;
    mmio_req_t bus_req;
    mmio_rsp_t bus_rsp;
    pad_buttons_t buttons;
    nibble_t flash_out;
    flash_pins_t flash;
    logic led_r;
    logic led_b;

    integer seed = 76620;
    int cycles = 0;
    int checks = 0;
    int test_errors = 0;
    int total_checks = 0;
    int errors = 0;
    data_t rdata;
    logic [3:0] sel;

    // Reference model state
    logic [1:0] m_status;
    shortint m_op_a;
    shortint m_op_b;
    logic [15:0] m_shift;
    logic m_pad_clk;
    logic m_pad_latch;
    logic [15:0] m_flash;

    periph_top u_dut (
        .vdp_clk(vdp_clk),
        .vdp_reset(vdp_reset),
        .bus_req(bus_req),
        .bus_rsp(bus_rsp),
        .buttons(buttons),
        .flash_out(flash_out),
        .flash(flash),
        .led_r(led_r),
        .led_b(led_b)
    );

    always #2 vdp_clk = ~vdp_clk;

    always @(posedge vdp_clk) begin
        cycles = cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: run stopped after %0d cycles", cycles);
            $display("Test FAILED");
            $finish;
        end
    end

    task automatic compare_value(input string name, input data_t got, input data_t exp);
        checks++;
        if (got !== exp) begin
            $display("MISMATCH %s got %h expected %h", name, got, exp);
            test_errors++;
        end
    endtask

    function automatic addr_t make_addr(input logic [3:0] target, input logic [15:0] low);
        logic [3:0] upper;
        upper = $random(seed);
        return {upper, target, low};
    endfunction

    // Idle pins unless the active bit is set
    function automatic flash_pins_t expect_pins(input logic [15:0] w);
        flash_pins_t p;
        p.clk_ddr = 2'b00;
        p.csn = 1'b1;
        p.data_in = 4'h0;
        p.data_in_en = 4'h0;
        if (w[`FLASH_ACTIVE_BIT]) begin
            p.clk_ddr = {2{w[`FLASH_CLK_BIT]}};
            p.csn = w[`FLASH_CSN_BIT];
            p.data_in = w[`FLASH_IN_LSB +: 4];
            p.data_in_en = w[`FLASH_EN_LSB +: 4];
        end
        return p;
    endfunction

    // Entered one step after a rising edge with the request already driven
    task automatic finish_transfer(input string who, output data_t rd);
        int waited;
        waited = 0;
        @(posedge vdp_clk);
        #1;
        while (!bus_rsp.ready && waited < 8) begin
            waited++;
            @(posedge vdp_clk);
            #1;
        end
        rd = bus_rsp.read_data;
        if (waited != 0) begin
            $display("%s: ready not seen one cycle after valid", who);
            test_errors++;
        end
        bus_req = '0;
        @(posedge vdp_clk);
        #1;
        if (bus_rsp.ready) begin
            $display("%s: ready stayed high for a second cycle", who);
            test_errors++;
        end
    endtask

    task automatic do_write(input addr_t addr, input data_t data);
        wstrb_t strb;
        data_t unused;
        strb = $random(seed);
        strb = (strb == '0) ? 4'hf : strb;
        bus_req.valid = 1'b1;
        bus_req.address = addr;
        bus_req.write_data = data;
        bus_req.wstrb = strb;
        finish_transfer("do_write", unused);
    endtask

    task automatic do_read(input addr_t addr, output data_t rd);
        bus_req.valid = 1'b1;
        bus_req.address = addr;
        bus_req.write_data = $random(seed);
        bus_req.wstrb = '0;
        finish_transfer("do_read", rd);
    endtask

    task automatic pad_write(input logic [1:0] ctrl);
        do_write(make_addr(`SEL_PAD, $random(seed)), {30'b0, ctrl});
        if (ctrl[1] && !m_pad_clk) begin
            m_shift = m_shift >> 1;
        end else if (ctrl[0]) begin
            m_shift = '0;
            m_shift[0] = buttons.btn_2;
            m_shift[6] = buttons.btn_3;
            m_shift[7] = buttons.btn_1;
        end
        m_pad_clk = ctrl[1];
        m_pad_latch = ctrl[0];
    endtask

    task automatic pad_check();
        // Buttons may move freely while the latch is low
        if (!m_pad_latch) begin
            buttons = $random(seed);
        end
        do_read(make_addr(`SEL_PAD, $random(seed)), rdata);
        compare_value("pad_bits", rdata, {30'b0, buttons.btn_u, m_shift[0]});
    endtask

    task automatic end_test(input string name);
        $display("%s: %0d checks, %0d errors", name, checks, test_errors);
        total_checks += checks;
        errors += test_errors;
        checks = 0;
        test_errors = 0;
    endtask

    initial begin
        bus_req = '0;
        buttons = '0;
        flash_out = '0;
        vdp_reset = 1'b1;
        m_status = `STATUS_RESET;
        m_flash = '0;
        m_pad_clk = 1'b0;
        m_pad_latch = 1'b0;
        repeat (3) @(posedge vdp_clk);
        #1;
        vdp_reset = 1'b0;

        compare_value("ready", bus_rsp.ready, 0);
        compare_value("leds", {led_b, led_r}, m_status);
        compare_value("flash", flash, expect_pins(m_flash));
        repeat (40) begin
            rdata = $random(seed);
            do_write(make_addr(`SEL_STATUS, $random(seed)), rdata);
            m_status = rdata[1:0];
            compare_value("leds", {led_b, led_r}, m_status);
        end
        end_test("reset and status");

        repeat (100) begin
            m_op_a = $random(seed);
            m_op_b = $random(seed);
            do_write(make_addr(`SEL_DSP, $random(seed) & 16'hfffb), m_op_a);
            do_write(make_addr(`SEL_DSP, $random(seed) | 16'h0004), m_op_b);
            do_read(make_addr(`SEL_DSP, $random(seed)), rdata);
            compare_value("dsp_result", rdata, int'(m_op_a) * int'(m_op_b));
        end
        end_test("dsp multiplier");

        repeat (4) begin
            buttons = $random(seed);
            pad_write(2'b01);
            pad_check();
            pad_write(2'b00);
            pad_check();
            repeat (16) begin
                pad_write(2'b10);
                pad_check();
                pad_write(2'b00);
                pad_check();
            end
        end
        end_test("gamepad");

        repeat (60) begin
            m_flash = $random(seed);
            do_write(make_addr(`SEL_FLASH, $random(seed)), m_flash);
            compare_value("flash", flash, expect_pins(m_flash));
            flash_out = $random(seed);
            do_read(make_addr(`SEL_FLASH, $random(seed)), rdata);
            compare_value("read_data", rdata, flash_out);
        end
        end_test("flash bit-bang");

        repeat (40) begin
            sel = $random(seed);
            sel = (sel < 4) ? sel + 4 : sel;
            do_read(make_addr(sel, $random(seed)), rdata);
            compare_value("read_data", rdata, 0);
            do_write(make_addr(sel, $random(seed)), $random(seed));
            compare_value("leds", {led_b, led_r}, m_status);
            compare_value("flash", flash, expect_pins(m_flash));
            do_read(make_addr(`SEL_DSP, $random(seed)), rdata);
            compare_value("dsp_result", rdata, int'(m_op_a) * int'(m_op_b));
        end
        end_test("unmapped");

        $display("Summary: 5 tests, %0d checks, %0d errors", total_checks, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule
